// ==== verilog.f ====
rtl/mem_pkg.sv
rtl/dmem_lane.sv
rtl/dmem_ctrl.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/mem_subsys.sv
test/tb_mem_subsys.sv

// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all lint clean

all: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee sim.log
	grep -q "PASS: all tests" sim.log

obj_dir/Vtb_mem_subsys: verilog.f $(SRCS)
	verilator --binary --timing -f verilog.f --top-module tb_mem_subsys -o Vtb_mem_subsys

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_mem_subsys

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_mem_subsys.sv ====
`timescale 1ns/1ns

module tb_mem_subsys;

  localparam int N_FILL = 256;
  localparam int N_ITEMS = 2000;
  localparam int N_TOTAL = N_FILL + N_ITEMS;
  // worst case about 4 cycles per item, doubled for random stalls
  localparam int MAX_CYCLES = N_TOTAL * 8;
  localparam int MEM_BYTES = 2048;

  typedef struct {
    mem_pkg::addr_t pc;
    mem_pkg::reg_idx_t rd_addr;
    logic rd_ena;
    mem_pkg::xlen_t data;
    int ready;
  } wb_rec_t;

  logic clk;
  logic rst;
  logic in_valid;
  mem_pkg::addr_t in_pc;
  mem_pkg::mem_op_t in_mem_op;
  mem_pkg::addr_t in_addr;
  mem_pkg::xlen_t in_store_data;
  mem_pkg::xlen_t in_alu_result;
  mem_pkg::reg_idx_t in_rd_addr;
  logic in_rd_ena;
  logic in_allowin;
  logic wb_valid;
  mem_pkg::addr_t wb_pc;
  mem_pkg::reg_idx_t wb_rd_addr;
  logic wb_rd_ena;
  mem_pkg::xlen_t wb_data;
  logic wb_allowin;
  logic fwd_valid;
  mem_pkg::reg_idx_t fwd_rd_addr;
  mem_pkg::xlen_t fwd_data;

  mem_pkg::byte_t model_mem [MEM_BYTES];
  wb_rec_t exp_q[$];
  int cycle_count;
  int issued;
  int retired;
  logic have_item;

  mem_subsys mem_subsys_inst (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_pc         (in_pc),
    .in_mem_op     (in_mem_op),
    .in_addr       (in_addr),
    .in_store_data (in_store_data),
    .in_alu_result (in_alu_result),
    .in_rd_addr    (in_rd_addr),
    .in_rd_ena     (in_rd_ena),
    .in_allowin    (in_allowin),
    .wb_valid      (wb_valid),
    .wb_pc         (wb_pc),
    .wb_rd_addr    (wb_rd_addr),
    .wb_rd_ena     (wb_rd_ena),
    .wb_data       (wb_data),
    .wb_allowin    (wb_allowin),
    .fwd_valid     (fwd_valid),
    .fwd_rd_addr   (fwd_rd_addr),
    .fwd_data      (fwd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_xlen(string name, mem_pkg::xlen_t got, mem_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(string name, mem_pkg::addr_t got, mem_pkg::addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(string name, mem_pkg::reg_idx_t got, mem_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic int op_bytes(mem_pkg::mem_op_t op);
    case (op)
      mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: return 1;
      mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: return 2;
      mem_pkg::OP_LW, mem_pkg::OP_LWU, mem_pkg::OP_SW: return 4;
      default: return 8;
    endcase
  endfunction

  // little-endian read from the model, then extend per op
  function automatic mem_pkg::xlen_t load_value(mem_pkg::mem_op_t op, int base);
    mem_pkg::xlen_t v;
    v = '0;
    for (int i = 0; i < op_bytes(op); i++) begin
      v[8*i +: 8] = model_mem[base + i];
    end
    case (op)
      mem_pkg::OP_LB: v = {{56{v[7]}}, v[7:0]};
      mem_pkg::OP_LH: v = {{48{v[15]}}, v[15:0]};
      mem_pkg::OP_LW: v = {{32{v[31]}}, v[31:0]};
      default: v = v;
    endcase
    return v;
  endfunction

  // preload pattern so no load sees unwritten lanes
  function automatic mem_pkg::xlen_t fill_word(mem_pkg::addr_t a);
    return {~a[31:0] ^ a[63:32], a[31:0] ^ 32'hc3a5_5a3c};
  endfunction

  task automatic make_item(int idx);
    int bytes;
    int base;
    in_pc = 64'h8000_0000 + mem_pkg::addr_t'(idx * 4);
    in_rd_addr = mem_pkg::reg_idx_t'($urandom_range(31));
    in_rd_ena = $urandom_range(1) == 1;
    in_alu_result = {$urandom, $urandom};
    in_store_data = {$urandom, $urandom};
    if (idx < N_FILL) begin
      in_mem_op = mem_pkg::OP_SD;
      in_addr = mem_pkg::addr_t'(idx * 8);
      in_store_data = fill_word(in_addr);
    end else begin
      in_mem_op = mem_pkg::mem_op_t'($urandom_range(11));
      bytes = op_bytes(in_mem_op);
      // mostly a 256-byte window so loads hit recent stores
      if ($urandom_range(3) != 0) begin
        base = 256 + int'($urandom_range(255));
      end else begin
        base = int'($urandom_range(MEM_BYTES - 1));
      end
      in_addr = mem_pkg::addr_t'(base & ~(bytes - 1));
    end
  endtask

  task automatic accept_item();
    wb_rec_t rec;
    int base;
    base = int'(in_addr[10:0]);
    rec.pc = in_pc;
    rec.rd_addr = in_rd_addr;
    rec.rd_ena = in_rd_ena;
    rec.ready = cycle_count + ((in_mem_op == mem_pkg::OP_NONE) ? 1 : 3);
    if (in_mem_op >= mem_pkg::OP_SB) begin
      for (int i = 0; i < op_bytes(in_mem_op); i++) begin
        model_mem[base + i] = in_store_data[8*i +: 8];
      end
      rec.data = in_addr;
    end else if (in_mem_op != mem_pkg::OP_NONE) begin
      rec.data = load_value(in_mem_op, base);
    end else begin
      rec.data = in_alu_result;
    end
    exp_q.push_back(rec);
  endtask

  task automatic check_outputs();
    wb_rec_t rec;
    logic exp_allowin;
    if (exp_q.size() == 0) begin
      check_bit("wb_valid", wb_valid, 1'b0);
      check_bit("fwd_valid", fwd_valid, 1'b0);
      check_bit("in_allowin", in_allowin, 1'b1);
    end else begin
      rec = exp_q[0];
      // stage frees up only when its item leaves
      exp_allowin = (cycle_count >= rec.ready) && wb_allowin;
      check_bit("wb_valid", wb_valid, cycle_count >= rec.ready);
      check_bit("in_allowin", in_allowin, exp_allowin);
      check_bit("fwd_valid", fwd_valid, rec.rd_ena);
      if (rec.rd_ena) begin
        check_reg("fwd_rd_addr", fwd_rd_addr, rec.rd_addr);
      end
      if (wb_valid) begin
        check_addr("wb_pc", wb_pc, rec.pc);
        check_reg("wb_rd_addr", wb_rd_addr, rec.rd_addr);
        check_bit("wb_rd_ena", wb_rd_ena, rec.rd_ena);
        check_xlen("wb_data", wb_data, rec.data);
        if (rec.rd_ena) begin
          check_xlen("fwd_data", fwd_data, rec.data);
        end
        if (wb_allowin) begin
          void'(exp_q.pop_front());
          retired++;
        end
      end
    end
  endtask

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d of %0d items written back",
             cycle_count, retired, N_TOTAL);
    stop_with_failure();
  end

  initial begin
    void'($urandom(32'hbd54_f6dc));
    rst = 1'b1;
    in_valid = 1'b0;
    in_pc = '0;
    in_mem_op = mem_pkg::OP_NONE;
    in_addr = '0;
    in_store_data = '0;
    in_alu_result = '0;
    in_rd_addr = '0;
    in_rd_ena = 1'b0;
    wb_allowin = 1'b0;
    issued = 0;
    retired = 0;
    have_item = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    #1;
    check_bit("wb_valid", wb_valid, 1'b0);
    check_bit("fwd_valid", fwd_valid, 1'b0);
    check_bit("in_allowin", in_allowin, 1'b1);
    while (issued < N_TOTAL || exp_q.size() > 0) begin
      @(negedge clk);
      if (!have_item && issued < N_TOTAL) begin
        make_item(issued);
        have_item = 1'b1;
      end
      in_valid = have_item && ($urandom_range(3) != 0);
      wb_allowin = $urandom_range(3) != 0;
      #1;
      check_outputs();
      if (in_valid && in_allowin) begin
        accept_item();
        have_item = 1'b0;
        issued++;
      end
    end
    if (exp_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("items still pending at the end of the run");
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// ==== rtl/mem_subsys.sv ====
`timescale 1ns/1ns

module mem_subsys (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  mem_pkg::addr_t    in_pc,
  input  mem_pkg::mem_op_t  in_mem_op,
  input  mem_pkg::addr_t    in_addr,
  input  mem_pkg::xlen_t    in_store_data,
  input  mem_pkg::xlen_t    in_alu_result,
  input  mem_pkg::reg_idx_t in_rd_addr,
  input  logic              in_rd_ena,
  output logic              in_allowin,
  output logic              wb_valid,
  output mem_pkg::addr_t    wb_pc,
  output mem_pkg::reg_idx_t wb_rd_addr,
  output logic              wb_rd_ena,
  output mem_pkg::xlen_t    wb_data,
  input  logic              wb_allowin,
  output logic              fwd_valid,
  output mem_pkg::reg_idx_t fwd_rd_addr,
  output mem_pkg::xlen_t    fwd_data
);

  // stage to controller
  logic rw_valid;
  logic rw_ready;
  logic rw_write;
  mem_pkg::addr_t rw_addr;
  mem_pkg::xlen_t rw_wdata;
  mem_pkg::size_t rw_size;
  mem_pkg::xlen_t rw_rdata;

  // controller to lanes and aligner
  mem_pkg::lane_mask_t lane_en;
  mem_pkg::lane_mask_t lane_we;
  mem_pkg::lane_idx_t lane_index;
  mem_pkg::byte_t [mem_pkg::LANES-1:0] lane_wdata;
  mem_pkg::byte_t [mem_pkg::LANES-1:0] lane_rdata;
  logic issue;
  mem_pkg::offset_t issue_offset;
  mem_pkg::size_t issue_size;

  mem_stage mem_stage_inst (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_pc         (in_pc),
    .in_mem_op     (in_mem_op),
    .in_addr       (in_addr),
    .in_store_data (in_store_data),
    .in_alu_result (in_alu_result),
    .in_rd_addr    (in_rd_addr),
    .in_rd_ena     (in_rd_ena),
    .in_allowin    (in_allowin),
    .wb_valid      (wb_valid),
    .wb_pc         (wb_pc),
    .wb_rd_addr    (wb_rd_addr),
    .wb_rd_ena     (wb_rd_ena),
    .wb_data       (wb_data),
    .wb_allowin    (wb_allowin),
    .fwd_valid     (fwd_valid),
    .fwd_rd_addr   (fwd_rd_addr),
    .fwd_data      (fwd_data),
    .rw_valid      (rw_valid),
    .rw_ready      (rw_ready),
    .rw_write      (rw_write),
    .rw_addr       (rw_addr),
    .rw_wdata      (rw_wdata),
    .rw_size       (rw_size),
    .rw_rdata      (rw_rdata)
  );

  dmem_ctrl dmem_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .rw_valid     (rw_valid),
    .rw_write     (rw_write),
    .rw_addr      (rw_addr),
    .rw_wdata     (rw_wdata),
    .rw_size      (rw_size),
    .rw_ready     (rw_ready),
    .lane_en      (lane_en),
    .lane_we      (lane_we),
    .lane_index   (lane_index),
    .lane_wdata   (lane_wdata),
    .issue        (issue),
    .issue_offset (issue_offset),
    .issue_size   (issue_size)
  );

  // one byte-wide RAM per lane
  for (genvar i = 0; i < mem_pkg::LANES; i++) begin : g_lane
    dmem_lane lane_inst (
      .clk   (clk),
      .en    (lane_en[i]),
      .we    (lane_we[i]),
      .index (lane_index),
      .wdata (lane_wdata[i]),
      .rdata (lane_rdata[i])
    );
  end

  load_align load_align_inst (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .issue_offset (issue_offset),
    .issue_size   (issue_size),
    .lane_rdata   (lane_rdata),
    .rw_rdata     (rw_rdata)
  );

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  mem_pkg::addr_t    in_pc,
  input  mem_pkg::mem_op_t  in_mem_op,
  input  mem_pkg::addr_t    in_addr,
  input  mem_pkg::xlen_t    in_store_data,
  input  mem_pkg::xlen_t    in_alu_result,
  input  mem_pkg::reg_idx_t in_rd_addr,
  input  logic              in_rd_ena,
  output logic              in_allowin,
  output logic              wb_valid,
  output mem_pkg::addr_t    wb_pc,
  output mem_pkg::reg_idx_t wb_rd_addr,
  output logic              wb_rd_ena,
  output mem_pkg::xlen_t    wb_data,
  input  logic              wb_allowin,
  output logic              fwd_valid,
  output mem_pkg::reg_idx_t fwd_rd_addr,
  output mem_pkg::xlen_t    fwd_data,
  output logic              rw_valid,
  input  logic              rw_ready,
  output logic              rw_write,
  output mem_pkg::addr_t    rw_addr,
  output mem_pkg::xlen_t    rw_wdata,
  output mem_pkg::size_t    rw_size,
  input  mem_pkg::xlen_t    rw_rdata
);

  typedef enum logic [1:0] {IDLE, ADDR, RETN} mem_state_t;

  mem_state_t state;
  logic valid;

  // pipeline register
  mem_pkg::addr_t pc_r;
  mem_pkg::mem_op_t op_r;
  mem_pkg::addr_t addr_r;
  mem_pkg::xlen_t sdata_r;
  mem_pkg::xlen_t alu_r;
  mem_pkg::reg_idx_t rd_addr_r;
  logic rd_ena_r;
  mem_pkg::xlen_t load_data;

  logic is_load;
  logic is_store;
  logic load_signed;
  logic complete;
  logic accept;
  logic in_is_mem;
  mem_pkg::xlen_t load_ext;

  // decode of the held operation
  always_comb begin
    is_load = op_r inside {mem_pkg::OP_LB, mem_pkg::OP_LH, mem_pkg::OP_LW, mem_pkg::OP_LD,
                           mem_pkg::OP_LBU, mem_pkg::OP_LHU, mem_pkg::OP_LWU};
    is_store = op_r inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW, mem_pkg::OP_SD};
    load_signed = op_r inside {mem_pkg::OP_LB, mem_pkg::OP_LH, mem_pkg::OP_LW};
    case (op_r)
      mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: rw_size = mem_pkg::SIZE_B;
      mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: rw_size = mem_pkg::SIZE_H;
      mem_pkg::OP_LW, mem_pkg::OP_LWU, mem_pkg::OP_SW: rw_size = mem_pkg::SIZE_W;
      default: rw_size = mem_pkg::SIZE_D;
    endcase
  end

  // rdata arrives right-justified with upper bytes zero
  always_comb begin
    case (rw_size)
      mem_pkg::SIZE_B: load_ext = {{(mem_pkg::XLEN-8){load_signed & rw_rdata[7]}},
                                   rw_rdata[7:0]};
      mem_pkg::SIZE_H: load_ext = {{(mem_pkg::XLEN-16){load_signed & rw_rdata[15]}},
                                   rw_rdata[15:0]};
      mem_pkg::SIZE_W: load_ext = {{(mem_pkg::XLEN-32){load_signed & rw_rdata[31]}},
                                   rw_rdata[31:0]};
      default: load_ext = rw_rdata;
    endcase
  end

  assign in_is_mem = in_mem_op != mem_pkg::OP_NONE;
  assign complete = !(is_load || is_store) || state == RETN;
  assign in_allowin = !valid || (complete && wb_allowin);
  assign accept = in_valid && in_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      state <= IDLE;
    end else begin
      if (in_allowin) begin
        valid <= in_valid;
      end
      if (accept) begin
        state <= in_is_mem ? ADDR : IDLE;
      end else if (state == ADDR && rw_ready) begin
        state <= RETN;
      end else if (in_allowin) begin
        // item left without a successor
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_r <= in_pc;
      op_r <= in_mem_op;
      addr_r <= in_addr;
      sdata_r <= in_store_data;
      alu_r <= in_alu_result;
      rd_addr_r <= in_rd_addr;
      rd_ena_r <= in_rd_ena;
    end
    if (state == ADDR && rw_ready) begin
      load_data <= load_ext;
    end
  end

  // memory request
  assign rw_valid = state == ADDR;
  assign rw_write = is_store;
  assign rw_addr = addr_r;
  assign rw_wdata = sdata_r;

  // write-back
  assign wb_valid = valid && complete;
  assign wb_pc = pc_r;
  assign wb_rd_addr = rd_addr_r;
  assign wb_rd_ena = rd_ena_r;
  assign wb_data = is_load ? load_data : (is_store ? addr_r : alu_r);

  // forward, load data only good once complete
  assign fwd_valid = valid && rd_ena_r;
  assign fwd_rd_addr = rd_addr_r;
  assign fwd_data = wb_data;

endmodule

// ==== rtl/load_align.sv ====
`timescale 1ns/1ns

module load_align (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                issue,
  input  mem_pkg::offset_t                    issue_offset,
  input  mem_pkg::size_t                      issue_size,
  input  mem_pkg::byte_t [mem_pkg::LANES-1:0] lane_rdata,
  output mem_pkg::xlen_t                      rw_rdata
);

  mem_pkg::offset_t offset_r;
  mem_pkg::size_t size_r;
  mem_pkg::xlen_t keep;

  always_ff @(posedge clk) begin
    if (rst) begin
      offset_r <= '0;
      size_r <= mem_pkg::SIZE_D;
    end else if (issue) begin
      offset_r <= issue_offset;
      size_r <= issue_size;
    end
  end

  always_comb begin
    case (size_r)
      mem_pkg::SIZE_B: keep = mem_pkg::xlen_t'(8'hff);
      mem_pkg::SIZE_H: keep = mem_pkg::xlen_t'(16'hffff);
      mem_pkg::SIZE_W: keep = mem_pkg::xlen_t'(32'hffff_ffff);
      default: keep = '1;
    endcase
  end

  // shift selected bytes down to bit 0
  assign rw_rdata = (lane_rdata >> {offset_r, 3'b000}) & keep;

endmodule

// ==== rtl/dmem_ctrl.sv ====
`timescale 1ns/1ns

module dmem_ctrl (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rw_valid,
  input  logic                                  rw_write,
  input  mem_pkg::addr_t                        rw_addr,
  input  mem_pkg::xlen_t                        rw_wdata,
  input  mem_pkg::size_t                        rw_size,
  output logic                                  rw_ready,
  output mem_pkg::lane_mask_t                   lane_en,
  output mem_pkg::lane_mask_t                   lane_we,
  output mem_pkg::lane_idx_t                    lane_index,
  output mem_pkg::byte_t [mem_pkg::LANES-1:0]   lane_wdata,
  output logic                                  issue,
  output mem_pkg::offset_t                      issue_offset,
  output mem_pkg::size_t                        issue_size
);

  logic pending;
  logic accept;
  mem_pkg::offset_t offset;
  mem_pkg::lane_mask_t size_mask;
  mem_pkg::lane_mask_t lane_mask;

  assign accept = rw_valid && !pending;
  assign offset = rw_addr[mem_pkg::OFFSET_W-1:0];

  always_comb begin
    case (rw_size)
      mem_pkg::SIZE_B: size_mask = mem_pkg::lane_mask_t'(8'h01);
      mem_pkg::SIZE_H: size_mask = mem_pkg::lane_mask_t'(8'h03);
      mem_pkg::SIZE_W: size_mask = mem_pkg::lane_mask_t'(8'h0f);
      default: size_mask = mem_pkg::lane_mask_t'(8'hff);
    endcase
  end

  assign lane_mask = size_mask << offset;

  assign lane_en = accept ? lane_mask : '0;
  assign lane_we = (accept && rw_write) ? lane_mask : '0;
  assign lane_index = rw_addr[mem_pkg::OFFSET_W +: mem_pkg::LANE_IDX_W];
  // store bytes moved up to their lanes
  assign lane_wdata = rw_wdata << {offset, 3'b000};

  assign issue = accept;
  assign issue_offset = offset;
  assign issue_size = rw_size;

  // high for the single cycle after accept
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= accept;
    end
  end

  assign rw_ready = pending;

endmodule

// ==== rtl/dmem_lane.sv ====
`timescale 1ns/1ns

module dmem_lane (
  input  logic               clk,
  input  logic               en,
  input  logic               we,
  input  mem_pkg::lane_idx_t index,
  input  mem_pkg::byte_t     wdata,
  output mem_pkg::byte_t     rdata
);

  mem_pkg::byte_t mem [mem_pkg::DMEM_DEPTH];

  // read data held until the next enabled read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[index] <= wdata;
      end else begin
        rdata <= mem[index];
      end
    end
  end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  // datapath
  localparam int XLEN = 64;
  localparam int REG_IDX_W = 5;

  // data memory geometry
  localparam int LANES = XLEN / 8;
  localparam int DMEM_DEPTH = 256;
  localparam int LANE_IDX_W = $clog2(DMEM_DEPTH);
  localparam int OFFSET_W = $clog2(LANES);

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [7:0] byte_t;

  // address bits 10:3 select the lane word, 2:0 the byte lane
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [LANES-1:0] lane_mask_t;

  typedef logic [3:0] mem_op_t;
  typedef logic [1:0] size_t;

  // operation codes
  localparam mem_op_t OP_NONE = 4'd0;
  localparam mem_op_t OP_LB = 4'd1;
  localparam mem_op_t OP_LH = 4'd2;
  localparam mem_op_t OP_LW = 4'd3;
  localparam mem_op_t OP_LD = 4'd4;
  localparam mem_op_t OP_LBU = 4'd5;
  localparam mem_op_t OP_LHU = 4'd6;
  localparam mem_op_t OP_LWU = 4'd7;
  localparam mem_op_t OP_SB = 4'd8;
  localparam mem_op_t OP_SH = 4'd9;
  localparam mem_op_t OP_SW = 4'd10;
  localparam mem_op_t OP_SD = 4'd11;

  // access size, 1/2/4/8 bytes
  localparam size_t SIZE_B = 2'd0;
  localparam size_t SIZE_H = 2'd1;
  localparam size_t SIZE_W = 2'd2;
  localparam size_t SIZE_D = 2'd3;

endpackage
